/* udp_tx_sys.f */
design/udp_pkg.sv
design/payload_fifo.sv
design/payload_gen.sv
design/udp_tx.sv
design/udp_tx_ctrl.sv
design/udp_tx_top.sv
tests/tb_udp_tx_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_udp_tx_top
FILELIST = udp_tx_sys.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the simulator output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_udp_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udp_tx_top;

    localparam int NUM_STARTS = 12;
    localparam int MAX_GAP    = 200;
    localparam int FRAME_LEN  = udp_pkg::HDR_LEN + udp_pkg::PAYLOAD_LEN;
    localparam int TIMEOUT_CYCLES = NUM_STARTS * (MAX_GAP + udp_pkg::BURST_BYTES +
                                    udp_pkg::DGRAMS_PER_BURST * 30 + 20);
    localparam int DRAIN_CYCLES = udp_pkg::BURST_BYTES + udp_pkg::DGRAMS_PER_BURST * 30 + 20;

    logic           clk;
    logic           rst;
    logic           start;
    logic           busy;
    udp_pkg::byte_t tx_data;
    logic           tx_valid;
    logic           tx_sof;

    int             errors    = 0;
    int             accepted  = 0;   // Starts seen while busy was low.
    int             dgrams    = 0;
    int             byte_pos  = 0;   // Position inside the current datagram.
    int             cycles    = 0;
    udp_pkg::byte_t model_cnt = 8'h00;
    logic           busy_q    = 1'b0;

    udp_tx_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .busy     (busy),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_sof   (tx_sof)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    // Header bytes high byte first: source port, destination port, length, checksum.
    function automatic udp_pkg::byte_t header_byte(input int pos);
        logic [15:0] field;
        case (pos / 2)
            0: field = udp_pkg::SRC_PORT;
            1: field = udp_pkg::DST_PORT;
            2: field = 16'(FRAME_LEN);
            default: field = 16'h0000; // Checksum is not computed.
        endcase
        if (pos % 2 == 0)
            return field[15:8];
        else
            return field[7:0];
    endfunction

    // Monitor and model, sampled mid-cycle where everything is settled.
    always @(negedge clk) begin
        if (!rst) begin
            if (accepted == 0) begin
                assert (!busy && !tx_valid && !tx_sof) else begin
                    errors++;
                    $display("busy, tx_valid or tx_sof went high before any start");
                end
            end

            // End of a burst. A start in this same cycle belongs to the next one.
            if (busy_q && !busy) begin
                assert (dgrams == udp_pkg::DGRAMS_PER_BURST * accepted) else
                    report_mismatch("datagrams per burst",
                                    udp_pkg::DGRAMS_PER_BURST * accepted, dgrams);
            end

            if (start && !busy)
                accepted++;

            if (tx_valid) begin
                assert (byte_pos < FRAME_LEN) else begin
                    errors++;
                    $display("tx_valid stayed high past the end of a datagram");
                end
                if (byte_pos < udp_pkg::HDR_LEN) begin
                    assert (tx_data == header_byte(byte_pos)) else
                        report_mismatch("header", int'(header_byte(byte_pos)), int'(tx_data));
                end else if (byte_pos < FRAME_LEN) begin
                    assert (tx_data == model_cnt) else
                        report_mismatch("payload", int'(model_cnt), int'(tx_data));
                    model_cnt = model_cnt + 8'd1; // Wraps at 256.
                end
                assert (tx_sof == (byte_pos == 0)) else
                    report_mismatch("sof", int'(byte_pos == 0), int'(tx_sof));
                byte_pos++;
            end else begin
                assert (!tx_sof) else
                    report_mismatch("sof without valid", 0, int'(tx_sof));
                if (byte_pos != 0) begin
                    assert (byte_pos == FRAME_LEN) else
                        report_mismatch("frame length", FRAME_LEN, byte_pos);
                    dgrams++;
                    byte_pos = 0;
                end
            end

            busy_q = busy;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with the DUT still busy, %0d errors so far",
                     cycles, errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int gap;
        int drain;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        void'($urandom(59));
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Random spacing, so some pulses land mid-burst and are ignored.
        for (int i = 0; i < NUM_STARTS; i++) begin
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end

        drain = 0;
        @(negedge clk);
        while ((busy || tx_valid) && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        repeat (2) @(negedge clk);

        assert (accepted > 0) else begin
            errors++;
            $display("no start was ever accepted");
        end
        assert (dgrams == udp_pkg::DGRAMS_PER_BURST * accepted) else
            report_mismatch("datagram total", udp_pkg::DGRAMS_PER_BURST * accepted, dgrams);
        assert (!busy) else begin
            errors++;
            $display("busy still high at the end of the run");
        end
        assert (byte_pos == 0) else begin
            errors++;
            $display("a datagram was left unfinished at the end of the run");
        end

        $display("Summary: %0d errors, %0d accepted starts, %0d datagrams, %0d cycles",
                 errors, accepted, dgrams, cycles);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/udp_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    output logic           busy,
    output udp_pkg::byte_t tx_data,
    output logic           tx_valid,
    output logic           tx_sof
);

    logic           fill_start;
    logic           fill_done;
    logic           send_start;
    logic           send_done;
    logic           wr_en;
    udp_pkg::byte_t wr_data;
    logic           rd_en;
    udp_pkg::byte_t rd_data;
    logic           full;

    udp_tx_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .fill_start (fill_start),
        .fill_done  (fill_done),
        .send_start (send_start),
        .send_done  (send_done)
    );

    payload_gen gen_i (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .full       (full),
        .fill_done  (fill_done),
        .wr_en      (wr_en),
        .wr_data    (wr_data)
    );

    // Empty is only checked inside the FIFO. The sequencer guarantees data.
    payload_fifo fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   ()
    );

    udp_tx tx_i (
        .clk        (clk),
        .rst        (rst),
        .send_start (send_start),
        .send_done  (send_done),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_sof     (tx_sof)
    );

endmodule

`default_nettype wire

/* design/udp_tx_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic fill_start,
    input  logic fill_done,
    output logic send_start,
    input  logic send_done
);

    udp_pkg::ctrl_state_t            state;
    logic [udp_pkg::DGRAM_CNT_W-1:0] dgram_cnt;
    logic                            last_dgram;

    assign busy       = (state != udp_pkg::CTRL_IDLE);
    assign last_dgram = (dgram_cnt == udp_pkg::DGRAM_CNT_W'(udp_pkg::DGRAMS_PER_BURST - 1));

    // Strobes are registered and fire on entry to FILL and SEND.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= udp_pkg::CTRL_IDLE;
            dgram_cnt  <= '0;
            fill_start <= 1'b0;
            send_start <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            send_start <= 1'b0;
            case (state)
                udp_pkg::CTRL_IDLE: begin
                    if (start) begin
                        state      <= udp_pkg::CTRL_FILL;
                        fill_start <= 1'b1;
                    end
                end
                udp_pkg::CTRL_FILL: begin
                    if (fill_done) begin
                        state      <= udp_pkg::CTRL_SEND;
                        send_start <= 1'b1;
                        dgram_cnt  <= '0;
                    end
                end
                udp_pkg::CTRL_SEND: begin
                    if (send_done) begin
                        dgram_cnt <= dgram_cnt + 1'b1;
                        if (last_dgram)
                            state <= udp_pkg::CTRL_DONE;
                        else
                            state <= udp_pkg::CTRL_GAP;
                    end
                end
                udp_pkg::CTRL_GAP: begin
                    state      <= udp_pkg::CTRL_SEND; // One idle cycle between datagrams.
                    send_start <= 1'b1;
                end
                udp_pkg::CTRL_DONE: begin
                    state <= udp_pkg::CTRL_IDLE;
                end
                default: begin
                    state <= udp_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    a_legal_state: assert property (
        @(posedge clk) disable iff (rst)
        state inside {udp_pkg::CTRL_IDLE, udp_pkg::CTRL_FILL, udp_pkg::CTRL_SEND,
                      udp_pkg::CTRL_GAP, udp_pkg::CTRL_DONE}
    );

endmodule

`default_nettype wire

/* design/udp_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx (
    input  logic           clk,
    input  logic           rst,
    input  logic           send_start,
    output logic           send_done,
    output logic           rd_en,
    input  udp_pkg::byte_t rd_data,
    output udp_pkg::byte_t tx_data,
    output logic           tx_valid,
    output logic           tx_sof
);

    udp_pkg::udp_state_t       state;
    logic [udp_pkg::IDX_W-1:0] idx;
    logic [8*udp_pkg::HDR_LEN-1:0] hdr;
    udp_pkg::byte_t            hdr_byte;
    logic                      hdr_last;
    logic                      data_last;

    // Header layout, high byte first. Checksum is left at zero.
    assign hdr = {udp_pkg::SRC_PORT, udp_pkg::DST_PORT, udp_pkg::UDP_LEN_FIELD, 16'h0000};

    always_comb begin
        hdr_byte = hdr[8*(udp_pkg::HDR_LEN-1-int'(idx)) +: 8];
    end

    assign hdr_last  = (idx == udp_pkg::IDX_W'(udp_pkg::HDR_LEN - 1));
    assign data_last = (idx == udp_pkg::IDX_W'(udp_pkg::PAYLOAD_LEN - 1));

    // First payload byte is prefetched on the first header cycle and
    // held in the FIFO output register. The rest are read one cycle ahead.
    assign rd_en = ((state == udp_pkg::TX_HDR) && (idx == '0)) ||
                   ((state == udp_pkg::TX_DATA) && !data_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= udp_pkg::TX_IDLE;
            idx       <= '0;
            tx_valid  <= 1'b0;
            tx_sof    <= 1'b0;
            send_done <= 1'b0;
        end else begin
            tx_sof    <= 1'b0;
            send_done <= 1'b0;
            case (state)
                udp_pkg::TX_IDLE: begin
                    tx_valid <= 1'b0;
                    // Last byte was on the bus this cycle.
                    if (tx_valid)
                        send_done <= 1'b1;
                    if (send_start) begin
                        state <= udp_pkg::TX_HDR;
                        idx   <= '0;
                    end
                end
                udp_pkg::TX_HDR: begin
                    tx_valid <= 1'b1;
                    tx_sof   <= (idx == '0);
                    if (hdr_last) begin
                        state <= udp_pkg::TX_DATA;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                udp_pkg::TX_DATA: begin
                    tx_valid <= 1'b1;
                    if (data_last) begin
                        state <= udp_pkg::TX_IDLE;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    state    <= udp_pkg::TX_IDLE;
                    tx_valid <= 1'b0;
                end
            endcase
        end
    end

    // Output byte register.
    always_ff @(posedge clk) begin
        if (state == udp_pkg::TX_HDR)
            tx_data <= hdr_byte;
        else if (state == udp_pkg::TX_DATA)
            tx_data <= rd_data;
    end

    a_start_in_idle: assert property (
        @(posedge clk) disable iff (rst) send_start |-> (state == udp_pkg::TX_IDLE)
    );

    // Framing promised to the sequencer: valid two cycles after the strobe.
    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst) send_start |-> ##2 (tx_valid && tx_sof)
    );

endmodule

`default_nettype wire

/* design/payload_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module payload_gen (
    input  logic           clk,
    input  logic           rst,
    input  logic           fill_start,
    input  logic           full,
    output logic           fill_done,
    output logic           wr_en,
    output udp_pkg::byte_t wr_data
);

    udp_pkg::byte_t                  byte_cnt;   // Runs on across bursts.
    logic [udp_pkg::BURST_CNT_W-1:0] left;

    // Write whenever bytes remain and the FIFO has room.
    assign wr_en   = (left != '0) && !full;
    assign wr_data = byte_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt  <= '0;
            left      <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                left <= udp_pkg::BURST_CNT_W'(udp_pkg::BURST_BYTES);
            end else if (wr_en) begin
                byte_cnt <= byte_cnt + 1'b1; // Wraps at 256.
                left     <= left - 1'b1;
                if (left == udp_pkg::BURST_CNT_W'(1))
                    fill_done <= 1'b1;
            end
        end
    end

    // A new fill may only be requested once the previous one has drained.
    a_no_restart: assert property (
        @(posedge clk) disable iff (rst) fill_start |-> (left == '0)
    );

endmodule

`default_nettype wire

/* design/payload_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module payload_fifo (
    input  logic          clk,
    input  logic          rst,
    input  logic          wr_en,
    input  udp_pkg::byte_t wr_data,
    input  logic          rd_en,
    output udp_pkg::byte_t rd_data,
    output logic          full,
    output logic          empty
);

    udp_pkg::byte_t mem [udp_pkg::FIFO_DEPTH];

    logic [udp_pkg::FIFO_ADDR_W-1:0] wr_ptr;
    logic [udp_pkg::FIFO_ADDR_W-1:0] rd_ptr;
    udp_pkg::fifo_cnt_t              count;
    logic                            do_wr;
    logic                            do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == udp_pkg::fifo_cnt_t'(udp_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Wrap by compare so a depth that is not a power of two also works.
                if (wr_ptr == udp_pkg::FIFO_ADDR_W'(udp_pkg::FIFO_DEPTH - 1))
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                if (rd_ptr == udp_pkg::FIFO_ADDR_W'(udp_pkg::FIFO_DEPTH - 1))
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr]; // Held until the next read.
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

`default_nettype wire

/* design/udp_pkg.sv */
`default_nettype none

package udp_pkg;

    localparam int PAYLOAD_LEN      = 16;
    localparam int HDR_LEN          = 8;
    localparam int UDP_LEN          = PAYLOAD_LEN + HDR_LEN;
    localparam int DGRAMS_PER_BURST = 4;
    localparam int BURST_BYTES      = PAYLOAD_LEN * DGRAMS_PER_BURST;
    localparam int FIFO_DEPTH       = 64;

    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BURST_CNT_W = $clog2(BURST_BYTES + 1);
    localparam int DGRAM_CNT_W = $clog2(DGRAMS_PER_BURST);
    localparam int IDX_W       = $clog2(PAYLOAD_LEN);   // Covers header and payload index.

    typedef logic [7:0]            byte_t;
    typedef logic [15:0]           port_t;
    typedef logic [15:0]           len_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    localparam port_t SRC_PORT = 16'h1F90;
    localparam port_t DST_PORT = 16'h1F90;
    localparam len_t  UDP_LEN_FIELD = len_t'(UDP_LEN);

    // Burst sequencer.
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_FILL,
        CTRL_SEND,
        CTRL_GAP,
        CTRL_DONE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_DATA
    } udp_state_t;

endpackage

`default_nettype wire
